// File: Makefile
TOP = tb_aes256_key_expand

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f rtl/*.sv sim/*.sv
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall rtl/aes_key_pkg.sv rtl/sub_word_unit.sv rtl/expand_ctrl.sv \
		rtl/round_key_mixer.sv rtl/aes256_key_expand.sv --top-module aes256_key_expand

clean:
	rm -rf obj_dir sim.log

// File: rtl/aes256_key_expand.sv
`timescale 1ns/1ps

module aes256_key_expand
    import aes_key_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic [KEY_BITS-1:0] key,
    output round_key_t          key_out,
    output logic                key_valid,
    output logic                done
);

    expand_ctl_t ctl;

    expand_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .ctl   (ctl)
    );

    // S-box lookup sits inside the mixer's key path
    round_key_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .ctl       (ctl),
        .key_out   (key_out),
        .key_valid (key_valid),
        .done      (done)
    );

endmodule

// File: rtl/aes_key_pkg.sv
package aes_key_pkg;

    localparam int KEY_BITS       = 256;
    localparam int BLOCK_BITS     = 128;
    localparam int WORD_BITS      = 32;
    localparam int NUM_ROUND_KEYS = 15;
    localparam int LAST_ROUND     = NUM_ROUND_KEYS - 1;

    // First Rcon byte, doubled after every even round key
    localparam logic [7:0] RCON_INIT = 8'h01;

    typedef logic [3:0] round_idx_t;

    typedef enum logic {
        ST_IDLE   = 1'b0,
        ST_EXPAND = 1'b1
    } expand_state_t;

    // Control word from the sequencer to the key mixer
    typedef struct packed {
        logic       load;      // Capture the cipher key
        logic       step;      // Produce the next round key
        round_idx_t index;     // Round key produced this cycle
        logic       use_rcon;  // Even-round rule
        logic [7:0] rcon;
    } expand_ctl_t;

    typedef struct packed {
        round_idx_t            index;
        logic [BLOCK_BITS-1:0] key;
    } round_key_t;

endpackage

// File: rtl/expand_ctrl.sv
`timescale 1ns/1ps

module expand_ctrl
    import aes_key_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output expand_ctl_t ctl
);

    expand_state_t state;
    logic          load_q;
    logic          step_q;
    round_idx_t    round_q;
    logic [7:0]    rcon_q;
    logic          even_step;

    // Round 0 only comes with load, so any even step is round 2 or later
    assign even_step = step_q & ~round_q[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            load_q  <= 1'b0;
            step_q  <= 1'b0;
            round_q <= '0;
            rcon_q  <= RCON_INIT;
        end else begin
            load_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    step_q <= 1'b0;
                    if (start) begin
                        state   <= ST_EXPAND;
                        load_q  <= 1'b1;
                        round_q <= '0;
                        rcon_q  <= RCON_INIT;
                    end
                end
                ST_EXPAND: begin
                    // start is ignored for the whole run
                    if (round_q == round_idx_t'(LAST_ROUND)) begin
                        state  <= ST_IDLE;
                        step_q <= 1'b0;
                    end else begin
                        step_q  <= 1'b1;
                        round_q <= round_q + 1'b1;
                    end
                    if (even_step) begin
                        rcon_q <= {rcon_q[6:0], 1'b0};  // Stops at 0x40, no reduction
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        ctl.load     = load_q;
        ctl.step     = step_q;
        ctl.index    = round_q;
        ctl.use_rcon = even_step;
        ctl.rcon     = rcon_q;
    end

endmodule

// File: rtl/round_key_mixer.sv
`timescale 1ns/1ps

module round_key_mixer
    import aes_key_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [KEY_BITS-1:0] key,
    input  expand_ctl_t         ctl,
    output round_key_t          key_out,
    output logic                key_valid,
    output logic                done
);

    localparam int WORDS = BLOCK_BITS / WORD_BITS;

    logic [BLOCK_BITS-1:0] prev_key;  // Round k-2
    logic [BLOCK_BITS-1:0] last_key;  // Round k-1
    logic [WORD_BITS-1:0]  sub_word;
    logic [WORD_BITS-1:0]  mix_word;
    logic [BLOCK_BITS-1:0] next_key;

    sub_word_unit u_sub_word (
        .word_in  (last_key[BLOCK_BITS-1 -: WORD_BITS]),
        .word_out (sub_word)
    );

    // RotWord and Rcon only on even rounds
    always_comb begin
        if (ctl.use_rcon) begin
            mix_word = {sub_word[WORD_BITS-9:0], sub_word[WORD_BITS-1 -: 8]}
                     ^ {ctl.rcon, {(WORD_BITS-8){1'b0}}};
        end else begin
            mix_word = sub_word;
        end
    end

    always_comb begin
        next_key[WORD_BITS-1:0] = prev_key[WORD_BITS-1:0] ^ mix_word;
        for (int j = 1; j < WORDS; j++) begin
            next_key[j*WORD_BITS +: WORD_BITS] = prev_key[j*WORD_BITS +: WORD_BITS]
                                               ^ next_key[(j-1)*WORD_BITS +: WORD_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.load) begin
            prev_key    <= key[BLOCK_BITS-1:0];
            last_key    <= key[KEY_BITS-1:BLOCK_BITS];
            key_out.key <= key[BLOCK_BITS-1:0];
        end else if (ctl.step) begin
            if (ctl.index == round_idx_t'(1)) begin
                key_out.key <= last_key;  // Upper key half, pair stays put
            end else begin
                key_out.key <= next_key;
                prev_key    <= last_key;
                last_key    <= next_key;
            end
        end
        if (ctl.load || ctl.step) begin
            key_out.index <= ctl.index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            key_valid <= ctl.load | ctl.step;
            done      <= ctl.step && (ctl.index == round_idx_t'(LAST_ROUND));
        end
    end

endmodule

// File: rtl/sub_word_unit.sv
`timescale 1ns/1ps

module sub_word_unit
    import aes_key_pkg::*;
(
    input  logic [WORD_BITS-1:0] word_in,
    output logic [WORD_BITS-1:0] word_out
);

    // AES S-box, one row of 16 entries per line, entry 0x00 leftmost
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // All four bytes looked up in parallel
    for (genvar i = 0; i < WORD_BITS / 8; i++) begin : g_byte
        assign word_out[8*i +: 8] = SBOX[word_in[8*i +: 8]];
    end

endmodule

// File: sim/key_expand_asserts.sv
`timescale 1ns/1ps

module key_expand_asserts
    import aes_key_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       key_valid,
    input logic       done,
    input round_idx_t index
);

    // done marks the final round key only
    assert property (@(posedge clk) disable iff (rst)
        done |-> key_valid && index == round_idx_t'(LAST_ROUND))
        else $error("done seen without a valid round key 14");

    assert property (@(posedge clk) disable iff (rst)
        key_valid && !done |=> index == round_idx_t'($past(index) + 1'b1))
        else $error("round index did not advance by one");

    // No gaps inside a run
    assert property (@(posedge clk) disable iff (rst)
        key_valid && !done |=> key_valid)
        else $error("key_valid dropped before done");

endmodule

bind aes256_key_expand key_expand_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .key_valid (key_valid),
    .done      (done),
    .index     (key_out.index)
);

// File: sim/tb_aes256_key_expand.sv
`timescale 1ns/1ps

module tb_aes256_key_expand
    import aes_key_pkg::*;
();

    localparam int NUM_RANDOM  = 6;
    localparam int NUM_ROWS    = 2 + NUM_RANDOM;
    localparam int KEY0_DELAY  = 2;   // Falling edges from driving start to key 0
    localparam int WAIT_LIMIT  = 50;
    localparam int IDLE_CHECKS = 12;

    // Published schedules in FIPS-197 text order
    localparam logic [KEY_BITS-1:0] FIPS_KEY_TEXT =
        256'h603deb10_15ca71be_2b73aef0_857d7781_1f352c07_3b6108d7_2d9810a3_0914dff4;

    localparam logic [BLOCK_BITS-1:0] FIPS_KEYS [NUM_ROUND_KEYS] = '{
        128'h603deb10_15ca71be_2b73aef0_857d7781, 128'h1f352c07_3b6108d7_2d9810a3_0914dff4,
        128'h9ba35411_8e6925af_a51a8b5f_2067fcde, 128'ha8b09c1a_93d194cd_be49846e_b75d5b9a,
        128'hd59aecb8_5bf3c917_fee94248_de8ebe96, 128'hb5a9328a_2678a647_98312229_2f6c79b3,
        128'h812c81ad_dadf48ba_24360af2_fab8b464, 128'h98c5bfc9_bebd198e_268c3ba7_09e04214,
        128'h68007bac_b2df3316_96e939e4_6c518d80, 128'hc814e204_76a9fb8a_5025c02d_59c58239,
        128'hde136967_6ccc5a71_fa256395_9674ee15, 128'h5886ca5d_2e2f31d7_7e0af1fa_27cf73c3,
        128'h749c47ab_18501dda_e2757e4f_7401905a, 128'hcafaaae3_e4d59b34_9adf6ace_bd10190d,
        128'hfe4890d1_e6188d0b_046df344_706c631e
    };

    localparam logic [BLOCK_BITS-1:0] ZERO_KEYS [NUM_ROUND_KEYS] = '{
        128'h00000000_00000000_00000000_00000000, 128'h00000000_00000000_00000000_00000000,
        128'h62636363_62636363_62636363_62636363, 128'haafbfbfb_aafbfbfb_aafbfbfb_aafbfbfb,
        128'h6f6c6ccf_0d0f0fac_6f6c6ccf_0d0f0fac, 128'h7d8d8d6a_d7767691_7d8d8d6a_d7767691,
        128'h5354edc1_5e5be26d_31378ea2_3c38810e, 128'h968a81c1_41fcf750_3c717a3a_eb070cab,
        128'h9eaa8f28_c0f16d45_f1c6e3e7_cdfe62e9, 128'h2b312bdf_6acddc8f_56bca6b5_bdbbaa1e,
        128'h6406fd52_a4f79017_553173f0_98cf1119, 128'h6dbba90b_07767584_51cad331_ec71792f,
        128'he7b0e89c_4347788b_16760b7b_8eb91a62, 128'h74ed0ba1_739b7e25_2251ad14_ce20d43b,
        128'h10f80a17_53bf729c_45c979e7_cb706385
    };

    typedef struct packed {
        logic                has_expected;  // Otherwise rule check only
        logic                disturb;       // Extra start pulse mid-run
        logic                chain;         // Next run starts with key 14
        logic [KEY_BITS-1:0] key;
    } test_row_t;

    logic                clk;
    logic                rst;
    logic                start;
    logic [KEY_BITS-1:0] key;
    round_key_t          key_out;
    logic                key_valid;
    logic                done;

    test_row_t             rows [NUM_ROWS];
    string                 row_names [NUM_ROWS];
    logic [BLOCK_BITS-1:0] expected [NUM_ROWS][NUM_ROUND_KEYS];
    logic [BLOCK_BITS-1:0] got [NUM_ROUND_KEYS];
    int                    error_count;
    int                    timeout_count;

    aes256_key_expand dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .key       (key),
        .key_out   (key_out),
        .key_valid (key_valid),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // FIPS-197 lists word 0 first but the DUT keeps it in the low bits
    function automatic logic [BLOCK_BITS-1:0] block_from_text(input logic [BLOCK_BITS-1:0] text);
        logic [BLOCK_BITS-1:0] block;
        for (int j = 0; j < BLOCK_BITS / WORD_BITS; j++) begin
            block[WORD_BITS*j +: WORD_BITS] = text[WORD_BITS*(3-j) +: WORD_BITS];
        end
        return block;
    endfunction

    function automatic logic [KEY_BITS-1:0] key_from_text(input logic [KEY_BITS-1:0] text);
        return {block_from_text(text[BLOCK_BITS-1:0]),
                block_from_text(text[KEY_BITS-1:BLOCK_BITS])};
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [BLOCK_BITS-1:0] exp_val,
                                   input logic [BLOCK_BITS-1:0] act_val);
        error_count++;
        $display("[ERROR] %s: %s expected %0h, actual %0h", name, what, exp_val, act_val);
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r] = '0;
        end
        row_names[0]         = "fips197_vector";
        rows[0].has_expected = 1'b1;
        rows[0].chain        = 1'b1;
        rows[0].key          = key_from_text(FIPS_KEY_TEXT);
        row_names[1]         = "all_zero_key";
        rows[1].has_expected = 1'b1;
        rows[1].disturb      = 1'b1;
        for (int k = 0; k < NUM_ROUND_KEYS; k++) begin
            expected[0][k] = block_from_text(FIPS_KEYS[k]);
            expected[1][k] = block_from_text(ZERO_KEYS[k]);
        end
        for (int r = 2; r < NUM_ROWS; r++) begin
            row_names[r]    = $sformatf("random_key_%0d", r - 2);
            rows[r].disturb = (r == 4);
            for (int w = 0; w < KEY_BITS / WORD_BITS; w++) begin
                rows[r].key[WORD_BITS*w +: WORD_BITS] = $urandom();
            end
        end
    endtask

    task automatic check_idle(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (key_valid !== 1'b0) begin
                report_mismatch(name, "idle key_valid", '0, BLOCK_BITS'(key_valid));
            end
            if (done !== 1'b0) begin
                report_mismatch(name, "idle done", '0, BLOCK_BITS'(done));
            end
        end
    endtask

    // started means start was already driven with the previous key 14
    task automatic run_row(input int r, input logic started);
        int   waited;
        logic exp_done;
        if (!started) begin
            @(negedge clk);
            start = 1'b1;
            key   = rows[r].key;
        end
        @(negedge clk);
        start  = 1'b0;
        waited = 1;
        while (key_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (key_valid !== 1'b1) begin
            timeout_count++;
            $display("Timeout: no key_valid within %0d cycles of start in %s",
                     WAIT_LIMIT, row_names[r]);
            return;
        end
        if (waited != KEY0_DELAY) begin
            report_mismatch(row_names[r], "start to key 0 delay",
                            BLOCK_BITS'(KEY0_DELAY), BLOCK_BITS'(waited));
        end
        for (int i = 0; i < NUM_ROUND_KEYS; i++) begin
            if (i > 0) begin
                @(negedge clk);
                start = 1'b0;
            end
            exp_done = (i == LAST_ROUND);
            if (key_valid !== 1'b1) begin
                report_mismatch(row_names[r], "key_valid", BLOCK_BITS'(1'b1),
                                BLOCK_BITS'(key_valid));
            end
            if (key_out.index !== round_idx_t'(i)) begin
                report_mismatch(row_names[r], "index", BLOCK_BITS'(i),
                                BLOCK_BITS'(key_out.index));
            end
            if (done !== exp_done) begin
                report_mismatch(row_names[r], $sformatf("done at index %0d", i),
                                BLOCK_BITS'(exp_done), BLOCK_BITS'(done));
            end
            got[i] = key_out.key;
            if (rows[r].disturb && i == NUM_ROUND_KEYS / 2) begin
                start = 1'b1;  // Must be ignored
                key   = ~rows[r].key;
            end
            if (rows[r].chain && i == LAST_ROUND && r + 1 < NUM_ROWS) begin
                start = 1'b1;
                key   = rows[r + 1].key;
            end
        end
    endtask

    task automatic check_keys(input int r);
        logic [WORD_BITS-1:0] chain_word;
        if (rows[r].has_expected) begin
            for (int k = 0; k < NUM_ROUND_KEYS; k++) begin
                if (got[k] !== expected[r][k]) begin
                    report_mismatch(row_names[r], $sformatf("round key %0d", k),
                                    expected[r][k], got[k]);
                end
            end
        end
        // Rules that hold for any key
        if (got[0] !== rows[r].key[BLOCK_BITS-1:0]) begin
            report_mismatch(row_names[r], "round key 0", rows[r].key[BLOCK_BITS-1:0], got[0]);
        end
        if (got[1] !== rows[r].key[KEY_BITS-1:BLOCK_BITS]) begin
            report_mismatch(row_names[r], "round key 1",
                            rows[r].key[KEY_BITS-1:BLOCK_BITS], got[1]);
        end
        for (int k = 2; k < NUM_ROUND_KEYS; k++) begin
            for (int j = 1; j < BLOCK_BITS / WORD_BITS; j++) begin
                chain_word = got[k-2][WORD_BITS*j +: WORD_BITS]
                           ^ got[k][WORD_BITS*(j-1) +: WORD_BITS];
                if (got[k][WORD_BITS*j +: WORD_BITS] !== chain_word) begin
                    report_mismatch(row_names[r], $sformatf("round key %0d word %0d", k, j),
                                    BLOCK_BITS'(chain_word),
                                    BLOCK_BITS'(got[k][WORD_BITS*j +: WORD_BITS]));
                end
            end
        end
    endtask

    initial begin
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        start         = 1'b0;
        key           = '0;
        void'($urandom(1176));
        build_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_idle("idle_after_reset", IDLE_CHECKS);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r, r > 0 && rows[r - 1].chain);
            if (timeout_count != 0) begin
                break;
            end
            check_keys(r);
            if (!rows[r].chain) begin
                check_idle(row_names[r], 2);  // Run ends after key 14
            end
        end
        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/aes_key_pkg.sv
rtl/sub_word_unit.sv
rtl/expand_ctrl.sv
rtl/round_key_mixer.sv
rtl/aes256_key_expand.sv
sim/key_expand_asserts.sv
sim/tb_aes256_key_expand.sv
